/* rv_isa_pkg.sv */
package rv_isa_pkg;

  // base integer width
  localparam int XLEN = 32;

  // major opcodes
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

  // branch conditions
  localparam logic [2:0] F3_BEQ  = 3'b000;
  localparam logic [2:0] F3_BNE  = 3'b001;
  localparam logic [2:0] F3_BLT  = 3'b100;
  localparam logic [2:0] F3_BGE  = 3'b101;
  localparam logic [2:0] F3_BLTU = 3'b110;
  localparam logic [2:0] F3_BGEU = 3'b111;

  // register form, also the common opcode/funct3 view
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } inst_r_t;

  // system form, funct12 selects ecall/mret
  typedef struct packed {
    logic [11:0] funct12;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } inst_sys_t;

  typedef union packed {
    inst_r_t   r;
    inst_sys_t sys;
  } inst_u;

endpackage

/* ctrl_pkg.sv */
package ctrl_pkg;

  // alu operation class from the main decoder
  localparam logic [1:0] ALU_OP_ADD   = 2'd0;
  localparam logic [1:0] ALU_OP_SUB   = 2'd1;
  localparam logic [1:0] ALU_OP_FUNCT = 2'd2;

  // MEM-stage result select
  localparam logic [1:0] RESM_ALU      = 2'd0;
  localparam logic [1:0] RESM_IMM_PLUS = 2'd1;
  localparam logic [1:0] RESM_PC4      = 2'd2;

  // WB-stage result select
  localparam logic RESW_RESM = 1'b0;
  localparam logic RESW_LOAD = 1'b1;

  // base for the immediate adder: pc (auipc) or zero (lui)
  localparam logic IMMP_PC   = 1'b0;
  localparam logic IMMP_ZERO = 1'b1;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
    ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU
  } alu_ctrl_e;

  typedef enum logic [2:0] {IMM_I, IMM_S, IMM_B, IMM_U, IMM_J} imm_src_e;

  typedef enum logic [1:0] {
    PC_PLUS4, PC_BRANCH_TARGET, PC_JALR_TARGET, PC_TRAP_VECTOR
  } pc_src_e;

  typedef struct packed {
    logic zero;
    logic neg;
    logic neg_u;
  } alu_flags_t;

  typedef struct packed {
    logic result_w_src;
    logic reg_write;
  } wb_ctrl_t;

  typedef struct packed {
    logic       mem_req;
    logic       mem_write;
    logic [1:0] mem_size;
    logic       load_signed;
    logic [1:0] result_m_src;
    wb_ctrl_t   wb;
  } mem_ctrl_t;

  // alu_ctrl sits in the top bits
  typedef struct packed {
    alu_ctrl_e  alu_ctrl;
    logic       alu_src;
    logic       imm_plus_src;
    logic       ecall;
    logic [2:0] funct3;
    logic       branch;
    logic       jalr;
    mem_ctrl_t  mem;
  } ex_ctrl_t;

  typedef struct packed {
    imm_src_e imm_src;
    logic     jal;
    logic     ecall;
    logic     mret;
  } id_ctrl_t;

endpackage

/* main_decoder.sv */
`timescale 1ns/1ps

module main_decoder
  import rv_isa_pkg::*;
  import ctrl_pkg::*;
(
  input  inst_u      i_inst,
  output id_ctrl_t   o_id_ctrl,
  output ex_ctrl_t   o_ex_ctrl,
  output logic [1:0] o_alu_op
);

  logic sys_f3_zero;

  assign sys_f3_zero = (i_inst.sys.funct3 == 3'b000);

  always_comb begin
    o_id_ctrl = '0;
    o_ex_ctrl = '0;
    o_alu_op  = ALU_OP_ADD;
    o_ex_ctrl.funct3 = i_inst.r.funct3;

    case (i_inst.r.opcode)
      OPC_LOAD: begin
        o_id_ctrl.imm_src             = IMM_I;
        o_ex_ctrl.alu_src             = 1'b1;
        o_ex_ctrl.mem.mem_req         = 1'b1;
        o_ex_ctrl.mem.mem_size        = i_inst.r.funct3[1:0];
        o_ex_ctrl.mem.load_signed     = ~i_inst.r.funct3[2];
        o_ex_ctrl.mem.result_m_src    = RESM_ALU;
        o_ex_ctrl.mem.wb.result_w_src = RESW_LOAD;
        o_ex_ctrl.mem.wb.reg_write    = 1'b1;
      end
      OPC_STORE: begin
        o_id_ctrl.imm_src         = IMM_S;
        o_ex_ctrl.alu_src         = 1'b1;
        o_ex_ctrl.mem.mem_req     = 1'b1;
        o_ex_ctrl.mem.mem_write   = 1'b1;
        o_ex_ctrl.mem.mem_size    = i_inst.r.funct3[1:0];
        o_ex_ctrl.mem.load_signed = ~i_inst.r.funct3[2];
      end
      OPC_OP: begin
        o_alu_op                   = ALU_OP_FUNCT;
        o_ex_ctrl.mem.wb.reg_write = 1'b1;
      end
      OPC_OP_IMM: begin
        o_alu_op                   = ALU_OP_FUNCT;
        o_id_ctrl.imm_src          = IMM_I;
        o_ex_ctrl.alu_src          = 1'b1;
        o_ex_ctrl.mem.wb.reg_write = 1'b1;
      end
      OPC_BRANCH: begin
        // compare by subtraction, flags go to the branch resolver
        o_alu_op          = ALU_OP_SUB;
        o_id_ctrl.imm_src = IMM_B;
        o_ex_ctrl.branch  = 1'b1;
      end
      OPC_JAL: begin
        o_id_ctrl.imm_src          = IMM_J;
        o_id_ctrl.jal              = 1'b1;
        o_ex_ctrl.mem.result_m_src = RESM_PC4;
        o_ex_ctrl.mem.wb.reg_write = 1'b1;
      end
      OPC_JALR: begin
        o_id_ctrl.imm_src          = IMM_I;
        o_ex_ctrl.alu_src          = 1'b1;
        o_ex_ctrl.jalr             = 1'b1;
        o_ex_ctrl.mem.result_m_src = RESM_PC4;
        o_ex_ctrl.mem.wb.reg_write = 1'b1;
      end
      OPC_LUI, OPC_AUIPC: begin
        o_id_ctrl.imm_src          = IMM_U;
        o_ex_ctrl.imm_plus_src     = i_inst.r.opcode[5] ? IMMP_ZERO : IMMP_PC;
        o_ex_ctrl.mem.result_m_src = RESM_IMM_PLUS;
        o_ex_ctrl.mem.wb.reg_write = 1'b1;
      end
      OPC_SYSTEM: begin
        // only ecall and mret, other system words stay inert
        o_id_ctrl.ecall = sys_f3_zero && (i_inst.sys.funct12 == 12'h000);
        o_id_ctrl.mret  = sys_f3_zero && (i_inst.sys.funct12 == 12'h302);
        o_ex_ctrl.ecall = o_id_ctrl.ecall;
      end
      default: begin
        o_ex_ctrl = '0;
      end
    endcase
  end

endmodule

/* alu_decoder.sv */
`timescale 1ns/1ps

module alu_decoder
  import ctrl_pkg::*;
(
  input  logic [1:0] i_alu_op,
  input  logic [2:0] i_funct3,
  input  logic       i_op_b5,
  input  logic       i_funct7_b5,
  output alu_ctrl_e  o_alu_ctrl
);

  always_comb begin
    case (i_alu_op)
      ALU_OP_ADD: o_alu_ctrl = ALU_ADD;
      ALU_OP_SUB: o_alu_ctrl = ALU_SUB;
      ALU_OP_FUNCT: begin
        case (i_funct3)
          // sub only exists in the register form
          3'b000:  o_alu_ctrl = (i_op_b5 && i_funct7_b5) ? ALU_SUB : ALU_ADD;
          3'b001:  o_alu_ctrl = ALU_SLL;
          3'b010:  o_alu_ctrl = ALU_SLT;
          3'b011:  o_alu_ctrl = ALU_SLTU;
          3'b100:  o_alu_ctrl = ALU_XOR;
          // srai keeps funct7 bit 5 in the immediate
          3'b101:  o_alu_ctrl = i_funct7_b5 ? ALU_SRA : ALU_SRL;
          3'b110:  o_alu_ctrl = ALU_OR;
          default: o_alu_ctrl = ALU_AND;
        endcase
      end
      default: o_alu_ctrl = ALU_ADD;
    endcase
  end

endmodule

/* branch_resolver.sv */
`timescale 1ns/1ps

module branch_resolver
  import rv_isa_pkg::*;
  import ctrl_pkg::*;
(
  input  ex_ctrl_t   i_ex_ctrl,
  input  alu_flags_t i_flags,
  output pc_src_e    o_pc_src
);

  logic taken;

  // condition from the subtraction flags
  always_comb begin
    case (i_ex_ctrl.funct3)
      F3_BEQ:  taken = i_flags.zero;
      F3_BNE:  taken = ~i_flags.zero;
      F3_BLT:  taken = i_flags.neg;
      F3_BGE:  taken = ~i_flags.neg;
      F3_BLTU: taken = i_flags.neg_u;
      F3_BGEU: taken = ~i_flags.neg_u;
      default: taken = 1'b0;
    endcase
  end

  always_comb begin
    if (i_ex_ctrl.ecall) begin
      o_pc_src = PC_TRAP_VECTOR;
    end else if (i_ex_ctrl.jalr) begin
      o_pc_src = PC_JALR_TARGET;
    end else if (i_ex_ctrl.branch && taken) begin
      o_pc_src = PC_BRANCH_TARGET;
    end else begin
      o_pc_src = PC_PLUS4;
    end
  end

endmodule

/* ctrl_stage_regs.sv */
`timescale 1ns/1ps

module ctrl_stage_regs
  import ctrl_pkg::*;
(
  input  logic      clk,
  input  logic      i_arst_n,
  input  logic      i_flush,
  input  ex_ctrl_t  i_id_ex,
  output ex_ctrl_t  o_ex,
  output mem_ctrl_t o_mem,
  output wb_ctrl_t  o_wb
);

  // ID/EX, a flush turns the slot into a bubble
  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_ex <= '0;
    end else if (i_flush) begin
      o_ex <= '0;
    end else begin
      o_ex <= i_id_ex;
    end
  end

  // EX/MEM keeps only the memory and writeback part
  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_mem <= '0;
    end else begin
      o_mem <= o_ex.mem;
    end
  end

  // MEM/WB
  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_wb <= '0;
    end else begin
      o_wb <= o_mem.wb;
    end
  end

endmodule

/* rv_controller.sv */
`timescale 1ns/1ps

module rv_controller
  import rv_isa_pkg::*;
  import ctrl_pkg::*;
(
  input  logic       clk,
  input  logic       i_arst_n,
  input  inst_u      i_inst,
  input  alu_flags_t i_ex_flags,
  input  logic       i_ex_flush,
  output id_ctrl_t   o_id_ctrl,
  output ex_ctrl_t   o_ex_ctrl,
  output pc_src_e    o_ex_pc_src,
  output mem_ctrl_t  o_mem_ctrl,
  output wb_ctrl_t   o_wb_ctrl
);

  ex_ctrl_t   dec_ex_ctrl;
  ex_ctrl_t   id_ex_ctrl;
  logic [1:0] alu_op;
  alu_ctrl_e  alu_ctrl;

  // ID stage
  main_decoder u_main_decoder (
    .i_inst    (i_inst),
    .o_id_ctrl (o_id_ctrl),
    .o_ex_ctrl (dec_ex_ctrl),
    .o_alu_op  (alu_op)
  );

  alu_decoder u_alu_decoder (
    .i_alu_op    (alu_op),
    .i_funct3    (i_inst.r.funct3),
    .i_op_b5     (i_inst.r.opcode[5]),
    .i_funct7_b5 (i_inst.r.funct7[5]),
    .o_alu_ctrl  (alu_ctrl)
  );

  // alu_ctrl replaces the blank top field of the decoded bundle
  assign id_ex_ctrl = {alu_ctrl, dec_ex_ctrl[$bits(ex_ctrl_t)-$bits(alu_ctrl_e)-1:0]};

  ctrl_stage_regs u_stage_regs (
    .clk      (clk),
    .i_arst_n (i_arst_n),
    .i_flush  (i_ex_flush),
    .i_id_ex  (id_ex_ctrl),
    .o_ex     (o_ex_ctrl),
    .o_mem    (o_mem_ctrl),
    .o_wb     (o_wb_ctrl)
  );

  // EX stage
  branch_resolver u_branch_resolver (
    .i_ex_ctrl (o_ex_ctrl),
    .i_flags   (i_ex_flags),
    .o_pc_src  (o_ex_pc_src)
  );

endmodule

/* tb_rv_controller.sv */
`timescale 1ns/1ps

module tb_rv_controller
  import rv_isa_pkg::*;
  import ctrl_pkg::*;
();

  localparam int N_TESTS     = 3000;
  localparam int CLK_PERIOD  = 20;
  localparam int WATCHDOG_NS = (N_TESTS + 20) * CLK_PERIOD + 2000;

  logic       clk;
  logic       i_arst_n;
  inst_u      i_inst;
  alu_flags_t i_ex_flags;
  logic       i_ex_flush;
  id_ctrl_t   o_id_ctrl;
  ex_ctrl_t   o_ex_ctrl;
  pc_src_e    o_ex_pc_src;
  mem_ctrl_t  o_mem_ctrl;
  wb_ctrl_t   o_wb_ctrl;

  logic [31:0] lfsr;
  int          error_count;
  logic        checking;
  // expected EX bundle for the next 1, 2 and 3 cycles
  ex_ctrl_t    exp_q [3];

  rv_controller UUT (
    .clk         (clk),
    .i_arst_n    (i_arst_n),
    .i_inst      (i_inst),
    .i_ex_flags  (i_ex_flags),
    .i_ex_flush  (i_ex_flush),
    .o_id_ctrl   (o_id_ctrl),
    .o_ex_ctrl   (o_ex_ctrl),
    .o_ex_pc_src (o_ex_pc_src),
    .o_mem_ctrl  (o_mem_ctrl),
    .o_wb_ctrl   (o_wb_ctrl)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic draw(input int n, output logic [31:0] val);
    int i;
    val = '0;
    for (i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      val  = {val[30:0], lfsr[0]};
    end
  endtask

  function automatic void ref_decode(input inst_u ins, output id_ctrl_t id,
                                     output ex_ctrl_t ex);
    logic [6:0] opc;
    logic [2:0] f3;
    logic       is_load, is_store, is_op, is_opimm, is_branch;
    logic       is_jal, is_jalr, is_lui, is_auipc, is_sys;
    opc       = ins.r.opcode;
    f3        = ins.r.funct3;
    id        = '0;
    ex        = '0;
    is_load   = (opc == OPC_LOAD);
    is_store  = (opc == OPC_STORE);
    is_op     = (opc == OPC_OP);
    is_opimm  = (opc == OPC_OP_IMM);
    is_branch = (opc == OPC_BRANCH);
    is_jal    = (opc == OPC_JAL);
    is_jalr   = (opc == OPC_JALR);
    is_lui    = (opc == OPC_LUI);
    is_auipc  = (opc == OPC_AUIPC);
    is_sys    = (opc == OPC_SYSTEM);
    // unknown opcodes stay inert
    if (!(is_load || is_store || is_op || is_opimm || is_branch || is_jal || is_jalr ||
          is_lui || is_auipc || is_sys)) begin
      return;
    end
    ex.funct3 = f3;
    if (is_store) id.imm_src = IMM_S;
    else if (is_branch) id.imm_src = IMM_B;
    else if (is_lui || is_auipc) id.imm_src = IMM_U;
    else if (is_jal) id.imm_src = IMM_J;
    else id.imm_src = IMM_I;
    id.jal                 = is_jal;
    id.ecall               = is_sys && (f3 == 3'b000) && (ins.sys.funct12 == 12'h000);
    id.mret                = is_sys && (f3 == 3'b000) && (ins.sys.funct12 == 12'h302);
    ex.ecall               = id.ecall;
    ex.branch              = is_branch;
    ex.jalr                = is_jalr;
    ex.alu_src             = is_load || is_store || is_opimm || is_jalr;
    ex.imm_plus_src        = is_lui;
    ex.mem.mem_req         = is_load || is_store;
    ex.mem.mem_write       = is_store;
    ex.mem.wb.reg_write    = is_load || is_op || is_opimm || is_jal || is_jalr ||
                             is_lui || is_auipc;
    ex.mem.wb.result_w_src = is_load;
    if (is_load || is_store) begin
      ex.mem.mem_size    = f3[1:0];
      ex.mem.load_signed = ~f3[2];
    end
    if (is_jal || is_jalr) ex.mem.result_m_src = RESM_PC4;
    else if (is_lui || is_auipc) ex.mem.result_m_src = RESM_IMM_PLUS;
    else ex.mem.result_m_src = RESM_ALU;
    ex.alu_ctrl = ALU_ADD;
    if (is_branch) begin
      ex.alu_ctrl = ALU_SUB;
    end else if (is_op || is_opimm) begin
      case (f3)
        3'b000:  ex.alu_ctrl = (is_op && ins.r.funct7[5]) ? ALU_SUB : ALU_ADD;
        3'b001:  ex.alu_ctrl = ALU_SLL;
        3'b010:  ex.alu_ctrl = ALU_SLT;
        3'b011:  ex.alu_ctrl = ALU_SLTU;
        3'b100:  ex.alu_ctrl = ALU_XOR;
        3'b101:  ex.alu_ctrl = ins.r.funct7[5] ? ALU_SRA : ALU_SRL;
        3'b110:  ex.alu_ctrl = ALU_OR;
        default: ex.alu_ctrl = ALU_AND;
      endcase
    end
  endfunction

  function automatic pc_src_e ref_pc_src(input ex_ctrl_t ex, input alu_flags_t f);
    logic cond;
    case (ex.funct3)
      F3_BEQ:  cond = f.zero;
      F3_BNE:  cond = !f.zero;
      F3_BLT:  cond = f.neg;
      F3_BGE:  cond = !f.neg;
      F3_BLTU: cond = f.neg_u;
      F3_BGEU: cond = !f.neg_u;
      default: cond = 1'b0;
    endcase
    if (ex.ecall) return PC_TRAP_VECTOR;
    if (ex.jalr) return PC_JALR_TARGET;
    if (ex.branch && cond) return PC_BRANCH_TARGET;
    return PC_PLUS4;
  endfunction

  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    if (got !== exp) begin
      error_count++;
      $display("MISMATCH %s: got %h expected %h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic check_reset_state();
    compare_value("o_ex_ctrl", 32'(o_ex_ctrl), 32'h0);
    compare_value("o_mem_ctrl", 32'(o_mem_ctrl), 32'h0);
    compare_value("o_wb_ctrl", 32'(o_wb_ctrl), 32'h0);
    compare_value("o_ex_pc_src", 32'(o_ex_pc_src), 32'(PC_PLUS4));
  endtask

  // random fields, weighted opcode pick, system words steered to ecall/mret
  task automatic make_inst(output inst_u ins);
    logic [31:0] v;
    logic [31:0] sel;
    draw(25, v);
    ins = {v[24:0], 7'd0};
    draw(4, sel);
    case (sel[3:0])
      4'd0:    ins.r.opcode = OPC_LOAD;
      4'd1:    ins.r.opcode = OPC_STORE;
      4'd2:    ins.r.opcode = OPC_OP;
      4'd3:    ins.r.opcode = OPC_OP_IMM;
      4'd4:    ins.r.opcode = OPC_BRANCH;
      4'd5:    ins.r.opcode = OPC_JAL;
      4'd6:    ins.r.opcode = OPC_JALR;
      4'd7:    ins.r.opcode = OPC_LUI;
      4'd8:    ins.r.opcode = OPC_AUIPC;
      4'd9:    ins.r.opcode = OPC_SYSTEM;
      4'd10:   ins.r.opcode = OPC_OP;
      4'd11:   ins.r.opcode = OPC_OP_IMM;
      4'd12:   ins.r.opcode = OPC_BRANCH;
      4'd13:   ins.r.opcode = OPC_SYSTEM;
      4'd14:   ins.r.opcode = 7'b0001111;
      default: ins.r.opcode = 7'b1111111;
    endcase
    if (ins.r.opcode == OPC_SYSTEM) begin
      draw(3, sel);
      if (sel[1:0] == 2'd0) ins.sys.funct12 = 12'h000;
      if (sel[1:0] == 2'd1) ins.sys.funct12 = 12'h302;
      if (sel[2]) ins.sys.funct3 = 3'b000;
    end
  endtask

  // compare at the falling edge, then push this cycle's expectation
  always @(negedge clk) begin : compare_proc
    id_ctrl_t id_exp;
    ex_ctrl_t ex_exp;
    if (checking) begin
      ref_decode(i_inst, id_exp, ex_exp);
      compare_value("o_id_ctrl", 32'(o_id_ctrl), 32'(id_exp));
      compare_value("o_ex_ctrl.alu_ctrl", 32'(o_ex_ctrl.alu_ctrl), 32'(exp_q[0].alu_ctrl));
      compare_value("o_ex_ctrl", 32'(o_ex_ctrl), 32'(exp_q[0]));
      compare_value("o_ex_pc_src", 32'(o_ex_pc_src), 32'(ref_pc_src(exp_q[0], i_ex_flags)));
      compare_value("o_mem_ctrl", 32'(o_mem_ctrl), 32'(exp_q[1].mem));
      compare_value("o_wb_ctrl", 32'(o_wb_ctrl), 32'(exp_q[2].mem.wb));
      exp_q[2] = exp_q[1];
      exp_q[1] = exp_q[0];
      exp_q[0] = i_ex_flush ? ex_ctrl_t'('0) : ex_exp;
    end
  end

  initial begin
    inst_u       ins;
    logic [31:0] v;
    int          n;
    clk         = 1'b0;
    lfsr        = 32'h0dae88b1;
    error_count = 0;
    for (n = 0; n < 3; n++) begin
      exp_q[n] = '0;
    end
    checking   <= 1'b0;
    i_arst_n   <= 1'b0;
    i_inst     <= '0;
    i_ex_flags <= '0;
    i_ex_flush <= 1'b0;
    @(posedge clk);
    @(negedge clk);
    check_reset_state();
    @(posedge clk);
    i_arst_n <= 1'b1;
    checking <= 1'b1;
    for (n = 0; n < N_TESTS; n++) begin
      @(posedge clk);
      make_inst(ins);
      i_inst <= ins;
      draw(3, v);
      i_ex_flags <= alu_flags_t'(v[2:0]);
      draw(3, v);
      i_ex_flush <= (v[2:0] == 3'd0);
    end
    // let the last instructions drain to WB
    repeat (4) begin
      @(posedge clk);
      i_inst     <= '0;
      i_ex_flush <= 1'b0;
    end
    @(posedge clk);
    $display("errors: %0d mismatches over %0d instructions", error_count, N_TESTS);
    if (error_count == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("timeout: the run did not finish within %0d ns", WATCHDOG_NS);
    $display("STATUS: FAIL");
    $finish;
  end

endmodule

/* flist.f */
rv_isa_pkg.sv
ctrl_pkg.sv
main_decoder.sv
alu_decoder.sv
branch_resolver.sv
ctrl_stage_regs.sv
rv_controller.sv
tb_rv_controller.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the controller testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --top-module tb_rv_controller -f flist.f -o tb_rv_controller_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/tb_rv_controller_sim > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
  echo "simulation exited with status $run_status"
  exit 1
fi

if grep -q "STATUS: FAIL" "$LOG"; then
  exit 1
fi

exit 0
